/* cmd_stimulus.txt */
# F count frame-bytes | S pulses sum | M addr byte | L led | H reads during next frame
# counts in decimal, all other fields in hex
F 9 AA 20 00 04 01 02 03 04 20
S 1 000A
F 8 AA 20 00 03 FF FF FF DC
S 1 02FD
F 5 AA 20 00 00 20
S 1 0000
F 5 AA FF 00 00 FF
L 1
F 5 AA FF 00 00 FF
L 0
H 12
F 13 AA 10 00 08 11 22 33 44 55 66 77 88 90
S 0 0000
M 00 11
M 03 44
M 07 88
M 08 00
F 6 AA 10 00 01 99 77
S 0 0000
M 00 11
F 7 AA 20 00 02 05 06 21
S 1 000B
F 7 AA 30 00 02 AB CD 54
S 0 0000
M 01 22

/* files.f */
cmd_pkg.sv
frame_parser.sv
command_processor.sv
mem_store_unit.sv
checksum_unit.sv
mem_arbiter.sv
cmd_subsystem.sv
tb_cmd_subsystem.sv

/* Makefile */
# Verilator build and run of the command subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) cmd_stimulus.txt
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_cmd_subsystem.sv */
/*
 testbench for the command subsystem that plays frames from the stimulus file
 and checks sums, led level and data memory through host reads
*/
module tb_cmd_subsystem;

    localparam int    clk_period = 20;
    localparam int    read_limit = 100;  // cycles allowed for one host read
    localparam string stim_file  = "cmd_stimulus.txt";

    logic        clk;
    logic        rst_n;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rd_req;
    logic [5:0]  rd_addr;
    logic        rd_valid;
    logic [7:0]  rd_data;
    logic        led;
    logic        sum_valid;
    logic [15:0] sum_result;

    int          errors;
    int          test_errors;
    int          tests;
    int          seed;
    int          host_reads;        // random reads to overlap the next frame
    int          watchdog_cycles = 0;
    int          sum_count = 0;     // sum_valid pulses seen so far
    int          rd_count = 0;      // rd_valid pulses seen so far
    logic [15:0] last_sum;
    logic [7:0]  frame_q [$];

    cmd_subsystem #(
        .PAYLOAD_ADDR_WIDTH(8),
        .DATA_ADDR_WIDTH(6)
    ) dut0 (
        .clk, .rst_n, .rx_valid, .rx_data, .rd_req, .rd_addr,
        .rd_valid, .rd_data, .led, .sum_valid, .sum_result
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // pulse monitors on the falling edge
    always @(negedge clk) begin
        if (sum_valid) begin
            sum_count = sum_count + 1;
            last_sum  = sum_result;
        end
        if (rd_valid)
            rd_count = rd_count + 1;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    // ====================
    // helper tasks
    // ====================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error at time %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic send_frame();
        foreach (frame_q[i]) begin
            @(posedge clk);
            #2;
            rx_valid = 1'b1;
            rx_data  = frame_q[i];
        end
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
    endtask

    task automatic host_read(input logic [5:0] addr, output logic [7:0] data);
        int waited;
        int count_before;
        count_before = rd_count;
        @(posedge clk);
        #2;
        rd_req  = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        waited = 1;
        while (!rd_valid && waited < read_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        data = rd_data;
        #1;
        rd_req = 1'b0;  // dropped before the next edge so only one grant
        if (waited >= read_limit) begin
            $display("host read of address %0h got no rd_valid within %0d cycles",
                     addr, read_limit);
            errors++;
            test_errors++;
        end else begin
            // a second or stretched pulse is counted by this falling edge
            @(posedge clk);
            @(negedge clk);
            #1;
            check_value("rd_valid pulses", 1, rd_count - count_before);
        end
    endtask

    task automatic random_reads(input int n);
        logic [7:0] read_data;
        int         gap;
        for (int k = 0; k < n; k++) begin
            gap = $random(seed) & 1;
            repeat (gap) @(posedge clk);
            host_read(6'($random(seed)), read_data);
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        string      line;
        int         fd;
        int         nrec;
        int         n;
        int         value;
        int         addr;
        int         drain;
        int         sum_base;
        logic [7:0] kind;
        logic [7:0] b;
        logic [7:0] data;

        rst_n      = 1'b0;
        rx_valid   = 1'b0;
        rx_data    = 8'h00;
        rd_req     = 1'b0;
        rd_addr    = '0;
        errors     = 0;
        tests      = 0;
        nrec       = 0;
        host_reads = 0;
        sum_base   = 0;
        seed       = 32'h7997_b9ef;

        // first pass counts records for the watchdog
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("stimulus file %s could not be opened", stim_file);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0)
                if (line.len() > 1 && line.getc(0) != "#")
                    nrec++;
            $fclose(fd);
            fd = $fopen(stim_file, "r");
        end
        watchdog_cycles = 400 * nrec + 1000;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                void'($fgets(line, fd));  // comment line
            end else begin
                test_errors = 0;
                case (kind)
                    "F": begin
                        void'($fscanf(fd, "%d", n));
                        frame_q.delete();
                        for (int i = 0; i < n; i++) begin
                            void'($fscanf(fd, "%h", b));
                            frame_q.push_back(b);
                        end
                        // start and up to 8 cycles per byte with stalls, plus margin
                        drain = 20;
                        if (n >= 4)
                            drain = 8 * int'({frame_q[2], frame_q[3]}) + 20;
                        sum_base = sum_count;
                        send_frame();
                        fork
                            repeat (drain) @(posedge clk);
                            random_reads(host_reads);
                        join
                        host_reads = 0;
                    end
                    "S": begin
                        void'($fscanf(fd, "%d %h", n, value));
                        check_value("sum_valid count", n, sum_count - sum_base);
                        if (n > 0)
                            check_value("sum_result", value, 32'(last_sum));
                    end
                    "M": begin
                        void'($fscanf(fd, "%h %h", addr, value));
                        host_read(addr[5:0], data);
                        check_value("rd_data", value, 32'(data));
                    end
                    "L": begin
                        void'($fscanf(fd, "%h", value));
                        check_value("led", value, 32'(led));
                    end
                    "H": void'($fscanf(fd, "%d", host_reads));
                    default: begin
                        $display("stimulus file holds an unknown record kind %c", kind);
                        errors++;
                        test_errors++;
                    end
                endcase
                tests++;
                $display("test %0d (%c) %s", tests, kind, (test_errors == 0) ? "ok" : "failed");
            end
        end

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* cmd_subsystem.sv */
/*
 command subsystem top: frame parser, processor, store and sum executors, arbiter
 bytes come in on rx_valid strobes, the host reads data memory over rd_req
*/
module cmd_subsystem #(
    parameter int PAYLOAD_ADDR_WIDTH = 8,
    parameter int DATA_ADDR_WIDTH    = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rx_valid,
    input  logic [7:0]                 rx_data,
    input  logic                       rd_req,
    input  logic [DATA_ADDR_WIDTH-1:0] rd_addr,
    output logic                       rd_valid,
    output logic [7:0]                 rd_data,
    output logic                       led,
    output logic                       sum_valid,
    output logic [15:0]                sum_result
);

    cmd_pkg::frame_info_t          frame_info;
    cmd_pkg::cmd_bus_t             cmd_bus;
    cmd_pkg::mem_wr_t              mem_wr;
    logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_addr;
    logic [7:0]                    payload_read_data;
    logic                          store_ready;
    logic                          sum_ready;
    logic                          cmd_ready;
    logic                          wr_grant;

    assign cmd_ready = store_ready & sum_ready;  // all executors must accept

    frame_parser #(.PAYLOAD_ADDR_WIDTH(PAYLOAD_ADDR_WIDTH)) frame_parser0 (
        .clk, .rst_n, .rx_valid, .rx_data,
        .payload_read_addr, .frame_info, .payload_read_data
    );

    command_processor #(.PAYLOAD_ADDR_WIDTH(PAYLOAD_ADDR_WIDTH)) command_processor0 (
        .clk, .rst_n, .frame_info, .payload_read_data, .cmd_ready,
        .payload_read_addr, .led, .cmd_bus
    );

    mem_store_unit mem_store_unit0 (
        .clk, .rst_n, .cmd_bus, .wr_grant, .mem_wr, .ready(store_ready)
    );

    checksum_unit checksum_unit0 (
        .clk, .rst_n, .cmd_bus, .ready(sum_ready), .sum_valid, .sum_result
    );

    mem_arbiter #(.DATA_ADDR_WIDTH(DATA_ADDR_WIDTH)) mem_arbiter0 (
        .clk, .rst_n, .mem_wr, .rd_req, .rd_addr,
        .wr_grant, .rd_valid, .rd_data
    );

endmodule

/* mem_arbiter.sv */
/*
 data memory with round-robin access for the store writer and the host reader
 writes land in the grant cycle, reads return one cycle after the grant
*/
module mem_arbiter #(
    parameter int DATA_ADDR_WIDTH = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cmd_pkg::mem_wr_t           mem_wr,
    input  logic                       rd_req,
    input  logic [DATA_ADDR_WIDTH-1:0] rd_addr,
    output logic                       wr_grant,
    output logic                       rd_valid,
    output logic [7:0]                 rd_data
);

    localparam int DEPTH = 1 << DATA_ADDR_WIDTH;

    logic [7:0] mem [0:DEPTH-1];
    logic       last_rd;  // host was served last
    logic       rd_grant;

    // ====================
    // grant
    // ====================
    always_comb begin
        wr_grant = 1'b0;
        rd_grant = 1'b0;
        if (mem_wr.req && rd_req) begin
            wr_grant = last_rd;  // conflict goes to the other side
            rd_grant = ~last_rd;
        end else begin
            wr_grant = mem_wr.req;
            rd_grant = rd_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= 8'h00;
            last_rd  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_grant;
            if (wr_grant) begin
                mem[mem_wr.addr[DATA_ADDR_WIDTH-1:0]] <= mem_wr.data;
                last_rd <= 1'b0;
            end
            if (rd_grant)
                last_rd <= 1'b1;
        end
    end

    // read data
    always_ff @(posedge clk) begin
        if (rd_grant)
            rd_data <= mem[rd_addr];
    end

endmodule

/* checksum_unit.sv */
/*
 sum command executor, 16-bit wrap-around sum of the payload bytes
*/
module checksum_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_pkg::cmd_bus_t cmd_bus,
    output logic              ready,
    output logic              sum_valid,
    output logic [15:0]       sum_result
);

    logic        is_sum;
    logic [15:0] acc;
    logic [15:0] acc_base;
    logic [15:0] acc_next;

    assign is_sum   = (cmd_bus.cmd_type == cmd_pkg::cmd_sum);
    assign acc_base = cmd_bus.start ? 16'd0 : acc;  // start clears
    assign acc_next = cmd_bus.data_valid ? acc_base + 16'(cmd_bus.data) : acc_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc        <= '0;
            sum_valid  <= 1'b0;
            sum_result <= '0;
        end else begin
            sum_valid <= 1'b0;
            if (is_sum && (cmd_bus.start || cmd_bus.data_valid))
                acc <= acc_next;
            if (is_sum && cmd_bus.done) begin
                sum_result <= acc_next;  // includes the last byte
                sum_valid  <= 1'b1;
            end
        end
    end

    assign ready = 1'b1;  // never stalls

endmodule

/* mem_store_unit.sv */
/*
 store command executor, one-entry write buffer toward the memory arbiter
*/
module mem_store_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_pkg::cmd_bus_t cmd_bus,
    input  logic              wr_grant,
    output cmd_pkg::mem_wr_t  mem_wr,
    output logic              ready
);

    logic        buf_valid;
    logic [15:0] buf_addr;
    logic [7:0]  buf_data;
    logic        take;

    assign take = cmd_bus.data_valid && (cmd_bus.cmd_type == cmd_pkg::cmd_store);

    // buffer state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (take) begin
            buf_valid <= 1'b1;
        end else if (wr_grant) begin
            buf_valid <= 1'b0;  // written this cycle
        end
    end

    // buffer payload
    always_ff @(posedge clk) begin
        if (take) begin
            buf_addr <= cmd_bus.index;
            buf_data <= cmd_bus.data;
        end
    end

    assign mem_wr = '{req: buf_valid, addr: buf_addr, data: buf_data};
    assign ready  = ~buf_valid;  // full buffer stalls the processor

endmodule

/* command_processor.sv */
/*
 walks a parsed payload byte by byte and broadcasts it on the command bus
 heartbeat toggles the led, everything else is left to the executors
*/
module command_processor #(
    parameter int PAYLOAD_ADDR_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cmd_pkg::frame_info_t          frame_info,
    input  logic [7:0]                    payload_read_data,
    input  logic                          cmd_ready,
    output logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_addr,
    output logic                          led,
    output cmd_pkg::cmd_bus_t             cmd_bus
);

    // wait states cover the two-cycle RAM read
    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_set_addr = 3'd1;
    localparam logic [2:0] st_wait_1   = 3'd2;
    localparam logic [2:0] st_wait_2   = 3'd3;
    localparam logic [2:0] st_get_data = 3'd4;

    logic [2:0]  state;
    logic [15:0] data_counter;
    logic [15:0] current_length;
    logic        pd_d1;
    logic        pd_edge;  // registered rising edge of parse_done

    // ====================
    // parse_done edge
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pd_d1   <= 1'b0;
            pd_edge <= 1'b0;
        end else begin
            pd_d1   <= frame_info.parse_done;
            pd_edge <= frame_info.parse_done & ~pd_d1;
        end
    end

    // ====================
    // payload walker
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= st_idle;
            led               <= 1'b0;
            payload_read_addr <= '0;
            data_counter      <= '0;
            current_length    <= '0;
            cmd_bus           <= '0;
        end else begin
            // pulses default low
            cmd_bus.start      <= 1'b0;
            cmd_bus.data_valid <= 1'b0;
            cmd_bus.done       <= 1'b0;

            case (state)
                st_idle: begin
                    if (pd_edge) begin
                        cmd_bus.cmd_type <= frame_info.cmd;
                        cmd_bus.start    <= 1'b1;
                        current_length   <= frame_info.len;
                        data_counter     <= '0;
                        if (frame_info.cmd == cmd_pkg::cmd_heartbeat) begin
                            led            <= ~led;
                            cmd_bus.length <= '0;
                            cmd_bus.done   <= 1'b1;
                        end else if (frame_info.len == 16'd0) begin
                            cmd_bus.length <= '0;  // nothing to walk
                            cmd_bus.done   <= 1'b1;
                        end else begin
                            cmd_bus.length <= frame_info.len;
                            state          <= st_set_addr;
                        end
                    end
                end

                st_set_addr: begin
                    payload_read_addr <= data_counter[PAYLOAD_ADDR_WIDTH-1:0];
                    state             <= st_wait_1;
                end

                st_wait_1: state <= st_wait_2;  // RAM latches address
                st_wait_2: state <= st_get_data;  // RAM latches data

                st_get_data: begin
                    // hold here while an executor is busy, data stays put
                    if (cmd_ready) begin
                        cmd_bus.data       <= payload_read_data;
                        cmd_bus.index      <= data_counter;
                        cmd_bus.data_valid <= 1'b1;
                        if (data_counter == current_length - 16'd1) begin
                            cmd_bus.done <= 1'b1;
                            state        <= st_idle;
                        end else begin
                            data_counter <= data_counter + 16'd1;
                            state        <= st_set_addr;
                        end
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* frame_parser.sv */
/*
 byte-level frame parser: header, command, length, payload, xor checksum
 payload lands in a local RAM read back with two cycles of latency
*/
module frame_parser #(
    parameter int PAYLOAD_ADDR_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rx_valid,
    input  logic [7:0]                    rx_data,
    input  logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_addr,
    output cmd_pkg::frame_info_t          frame_info,
    output logic [7:0]                    payload_read_data
);

    localparam int DEPTH = 1 << PAYLOAD_ADDR_WIDTH;

    localparam logic [2:0] st_hdr     = 3'd0;
    localparam logic [2:0] st_cmd     = 3'd1;
    localparam logic [2:0] st_len_h   = 3'd2;
    localparam logic [2:0] st_len_l   = 3'd3;
    localparam logic [2:0] st_payload = 3'd4;
    localparam logic [2:0] st_csum    = 3'd5;

    logic [2:0]  state;
    logic [7:0]  cmd_q;
    logic [15:0] len_q;
    logic [15:0] len_next;
    logic [15:0] byte_cnt;  // payload bytes taken so far
    logic [7:0]  xor_q;     // running checksum
    logic        len_ok;    // payload fits the RAM
    logic        done_q;

    logic [7:0]                    ram [0:DEPTH-1];
    logic [PAYLOAD_ADDR_WIDTH-1:0] rd_addr_q;
    logic [7:0]                    rd_data_q;

    assign len_next = {len_q[15:8], rx_data};

    // ====================
    // frame FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_hdr;
            cmd_q    <= '0;
            len_q    <= '0;
            byte_cnt <= '0;
            xor_q    <= '0;
            len_ok   <= 1'b0;
            done_q   <= 1'b0;
        end else if (rx_valid) begin
            case (state)
                st_hdr: begin
                    if (rx_data == cmd_pkg::frame_hdr) begin
                        done_q <= 1'b0;  // previous result released here
                        state  <= st_cmd;
                    end
                end
                st_cmd: begin
                    cmd_q <= rx_data;
                    xor_q <= rx_data;
                    state <= st_len_h;
                end
                st_len_h: begin
                    len_q[15:8] <= rx_data;
                    xor_q       <= xor_q ^ rx_data;
                    state       <= st_len_l;
                end
                st_len_l: begin
                    len_q[7:0] <= rx_data;
                    xor_q      <= xor_q ^ rx_data;
                    byte_cnt   <= '0;
                    len_ok     <= (32'(len_next) <= DEPTH);
                    state      <= (len_next == 16'd0) ? st_csum : st_payload;
                end
                st_payload: begin
                    xor_q    <= xor_q ^ rx_data;
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt == len_q - 16'd1)
                        state <= st_csum;
                end
                st_csum: begin
                    // bad sum or oversize length: frame silently dropped
                    if (len_ok && xor_q == rx_data)
                        done_q <= 1'b1;
                    state <= st_hdr;
                end
                default: state <= st_hdr;
            endcase
        end
    end

    // ====================
    // payload RAM
    // ====================
    always_ff @(posedge clk) begin
        if (rx_valid && state == st_payload && len_ok)
            ram[byte_cnt[PAYLOAD_ADDR_WIDTH-1:0]] <= rx_data;
        rd_addr_q <= payload_read_addr;  // first read stage
        rd_data_q <= ram[rd_addr_q];     // second read stage
    end

    assign payload_read_data = rd_data_q;
    assign frame_info = '{cmd: cmd_q, len: len_q, parse_done: done_q};

endmodule

/* cmd_pkg.sv */
/*
 shared command codes, frame constants and bus structs for the command subsystem
 referenced by scoped name from every module, no import
*/
package cmd_pkg;

    // ====================
    // frame and command codes
    // ====================
    localparam logic [7:0] frame_hdr     = 8'hAA;
    localparam logic [7:0] cmd_store     = 8'h10;
    localparam logic [7:0] cmd_sum       = 8'h20;
    localparam logic [7:0] cmd_heartbeat = 8'hFF;

    // ====================
    // bus structs
    // ====================

    // processor to executors, 51 bits
    typedef struct packed {
        logic [7:0]  cmd_type;    // command code of the running frame
        logic [15:0] length;      // payload length
        logic [7:0]  data;        // current payload byte
        logic [15:0] index;       // position of data in the payload
        logic        start;       // pulse
        logic        data_valid;  // pulse
        logic        done;        // pulse, with last byte
    } cmd_bus_t;

    // store unit write request, 25 bits
    typedef struct packed {
        logic        req;
        logic [15:0] addr;  // arbiter takes low bits
        logic [7:0]  data;
    } mem_wr_t;

    // parser result, 25 bits
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] len;
        logic        parse_done;  // level, held until next header
    } frame_info_t;

endpackage
